/* common/serial_link_pkg.sv */
package serial_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumLanes = 4;

  // One beat across all data lanes
  typedef logic [NumLanes-1:0] lane_t;

  // Raw-mode word, sent lowest nibble first
  typedef logic [15:0] raw_word_t;

  localparam int BeatsPerWord = 4;

  // Transmit and receive FIFOs share the same depth
  localparam int FifoDepth = 8;

  // Fill count covers 0 to FifoDepth inclusive
  typedef logic [3:0] fill_t;

  ////////////////////////////////////////////////////////////////////////////
  // Clock divider
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [6:0] clk_div_t;

  localparam clk_div_t MinClkDiv   = 7'd4;
  localparam clk_div_t MaxClkDiv   = 7'd64;
  localparam clk_div_t ResetClkDiv = 7'd8;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone and register map
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  wb_adr_t;
  typedef logic [31:0] wb_data_t;

  localparam wb_adr_t RegCtrl      = 8'h00;
  localparam wb_adr_t RegClkDiv    = 8'h04;
  localparam wb_adr_t RegTxData    = 8'h08;
  localparam wb_adr_t RegTxStatus  = 8'h0C;
  localparam wb_adr_t RegRxData    = 8'h10;
  localparam wb_adr_t RegRxStatus  = 8'h14;
  localparam wb_adr_t RegFifoClear = 8'h18;

  // Transmitter FSM, one pass through LOW_HALF and HIGH_HALF per beat
  typedef enum logic [1:0] {
    IDLE,
    LOW_HALF,
    HIGH_HALF
  } phy_tx_state_e;

endpackage

/* design/serial_link_fifo.sv */
module serial_link_fifo #(
  parameter type data_t = logic
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   clear_i,
  input  logic                   push_i,
  input  data_t                  data_i,
  input  logic                   pop_i,
  output data_t                  data_o,
  output logic                   empty_o,
  output logic                   full_o,
  output serial_link_pkg::fill_t fill_o
);

  import serial_link_pkg::*;

  localparam int PtrW = $clog2(FifoDepth);

  data_t           mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  fill_t           fill_q;
  logic            do_push, do_pop;

  assign empty_o = (fill_q == '0);
  assign full_o  = (fill_q == fill_t'(FifoDepth));
  assign fill_o  = fill_q;
  assign data_o  = mem_q[rd_ptr_q];

  // Push when full and pop when empty are ignored
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        fill_q <= fill_q + 1'b1;
      end else if (do_pop && !do_push) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* design/serial_link_regs.sv */
module serial_link_regs (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Wishbone classic slave
  input  logic                       wb_cyc_i,
  input  logic                       wb_stb_i,
  input  logic                       wb_we_i,
  input  serial_link_pkg::wb_adr_t   wb_adr_i,
  input  serial_link_pkg::wb_data_t  wb_dat_i,
  output serial_link_pkg::wb_data_t  wb_dat_o,
  output logic                       wb_ack_o,
  // FIFO status
  input  serial_link_pkg::fill_t     tx_fill_i,
  input  logic                       tx_full_i,
  input  serial_link_pkg::raw_word_t rx_word_i,
  input  serial_link_pkg::fill_t     rx_fill_i,
  input  logic                       rx_empty_i,
  input  logic                       rx_full_i,
  input  logic                       rx_word_valid_i,
  // Control outputs
  output logic                       tx_en_o,
  output serial_link_pkg::clk_div_t  clk_div_o,
  output logic                       tx_push_o,
  output serial_link_pkg::raw_word_t tx_word_o,
  output logic                       tx_clear_o,
  output logic                       rx_pop_o,
  output logic                       rx_clear_o
);

  import serial_link_pkg::*;

  logic     ack_q;
  logic     tx_en_q;
  clk_div_t clk_div_q;
  logic     overflow_q;
  wb_data_t rdata;
  wb_data_t dat_q;

  logic req, wr, rd;

  // A new access is taken only in the cycle before its ack
  assign req = wb_cyc_i && wb_stb_i && !ack_q;
  assign wr  = req && wb_we_i;
  assign rd  = req && !wb_we_i;

  ////////////////////////////////////////////////////////////////////////////
  // FIFO strobes
  ////////////////////////////////////////////////////////////////////////////

  assign tx_push_o  = wr && (wb_adr_i == RegTxData);
  assign tx_word_o  = wb_dat_i[15:0];
  assign tx_clear_o = wr && (wb_adr_i == RegFifoClear) && wb_dat_i[0];
  assign rx_clear_o = wr && (wb_adr_i == RegFifoClear) && wb_dat_i[1];
  // Pop only a word that is really there
  assign rx_pop_o   = rd && (wb_adr_i == RegRxData) && !rx_empty_i;

  ////////////////////////////////////////////////////////////////////////////
  // Control and status registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q      <= 1'b0;
      tx_en_q    <= 1'b0;
      clk_div_q  <= ResetClkDiv;
      overflow_q <= 1'b0;
    end else begin
      ack_q <= req;

      if (wr && (wb_adr_i == RegCtrl)) begin
        tx_en_q <= wb_dat_i[0];
      end

      // Divider is clamped into the supported range
      if (wr && (wb_adr_i == RegClkDiv)) begin
        if (wb_dat_i < wb_data_t'(MinClkDiv)) begin
          clk_div_q <= MinClkDiv;
        end else if (wb_dat_i > wb_data_t'(MaxClkDiv)) begin
          clk_div_q <= MaxClkDiv;
        end else begin
          clk_div_q <= wb_dat_i[6:0];
        end
      end

      // A dropped word wins over a status read in the same cycle
      if (rx_word_valid_i && rx_full_i) begin
        overflow_q <= 1'b1;
      end else if (rd && (wb_adr_i == RegRxStatus)) begin
        overflow_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      RegCtrl:     rdata[0]    = tx_en_q;
      RegClkDiv:   rdata[6:0]  = clk_div_q;
      RegTxStatus: rdata[4:0]  = {tx_full_i, tx_fill_i};
      RegRxData:   rdata[16:0] = {!rx_empty_i, rx_word_i};
      RegRxStatus: rdata[4:0]  = {overflow_q, rx_fill_i};
      default:     rdata       = '0;
    endcase
  end

  // Read data is captured together with the ack
  always_ff @(posedge clk_i) begin
    if (rd) begin
      dat_q <= rdata;
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = dat_q;
  assign tx_en_o   = tx_en_q;
  assign clk_div_o = clk_div_q;

endmodule

/* phy/serial_link_phy_tx.sv */
module serial_link_phy_tx (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       tx_en_i,
  input  serial_link_pkg::clk_div_t  clk_div_i,
  input  serial_link_pkg::raw_word_t word_i,
  input  logic                       word_valid_i,
  output logic                       word_pop_o,
  output serial_link_pkg::lane_t     lane_o,
  output logic                       rcv_clk_o
);

  import serial_link_pkg::*;

  localparam int BeatW = $clog2(BeatsPerWord);

  phy_tx_state_e    state_q;
  clk_div_t         cnt_q, div_q, half_div;
  logic [BeatW-1:0] beat_q;
  raw_word_t        shift_q;
  lane_t            lane_q;
  logic             rcv_clk_q;
  logic             beat_end, word_end, load_word;

  // Forwarded clock rises halfway through the beat, centred on the data
  assign half_div  = div_q >> 1;
  assign beat_end  = (state_q == HIGH_HALF) && (cnt_q == div_q - 7'd1);
  assign word_end  = beat_end && (beat_q == BeatW'(BeatsPerWord - 1));
  // New words start only from idle or at a word boundary
  assign load_word = ((state_q == IDLE) || word_end) && tx_en_i && word_valid_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      beat_q    <= '0;
      lane_q    <= '0;
      rcv_clk_q <= 1'b0;
    end else begin
      case (state_q)
        LOW_HALF: begin
          cnt_q <= cnt_q + 7'd1;
          if (cnt_q == half_div - 7'd1) begin
            rcv_clk_q <= 1'b1;
            state_q   <= HIGH_HALF;
          end
        end
        HIGH_HALF: begin
          cnt_q <= cnt_q + 7'd1;
          if (beat_end) begin
            rcv_clk_q <= 1'b0;
            cnt_q     <= '0;
            if (!word_end) begin
              lane_q  <= shift_q[NumLanes-1:0];
              beat_q  <= beat_q + 1'b1;
              state_q <= LOW_HALF;
            end else begin
              state_q <= IDLE;
            end
          end
        end
        default: ;
      endcase

      if (load_word) begin
        lane_q  <= word_i[NumLanes-1:0];
        cnt_q   <= '0;
        beat_q  <= '0;
        state_q <= LOW_HALF;
      end
    end
  end

  // Remaining nibbles and the divider for the word in flight
  always_ff @(posedge clk_i) begin
    if (load_word) begin
      shift_q <= word_i >> NumLanes;
      div_q   <= clk_div_i;
    end else if (beat_end && !word_end) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

  assign word_pop_o = load_word;
  assign lane_o     = lane_q;
  assign rcv_clk_o  = rcv_clk_q;

endmodule

/* phy/serial_link_phy_rx.sv */
module serial_link_phy_rx (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  serial_link_pkg::lane_t     lane_i,
  input  logic                       rcv_clk_i,
  output serial_link_pkg::raw_word_t word_o,
  output logic                       word_valid_o
);

  import serial_link_pkg::*;

  localparam int BeatW = $clog2(BeatsPerWord);

  // Clock and lanes share one synchronizer so they stay aligned
  logic [NumLanes:0] sync1_q, sync2_q;
  logic              clk_prev_q;
  logic              clk_rise;
  lane_t             lane_sync;

  logic [BeatW-1:0]  beat_q;
  raw_word_t         shift_q;
  logic              valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizer and edge detect
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      clk_prev_q <= 1'b0;
    end else begin
      sync1_q    <= {rcv_clk_i, lane_i};
      sync2_q    <= sync1_q;
      clk_prev_q <= sync2_q[NumLanes];
    end
  end

  assign clk_rise  = sync2_q[NumLanes] && !clk_prev_q;
  assign lane_sync = sync2_q[NumLanes-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      beat_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= clk_rise && (beat_q == BeatW'(BeatsPerWord - 1));
      if (clk_rise) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // First nibble ends up in the low bits
  always_ff @(posedge clk_i) begin
    if (clk_rise) begin
      shift_q <= {lane_sync, shift_q[$bits(raw_word_t)-1:NumLanes]};
    end
  end

  assign word_o       = shift_q;
  assign word_valid_o = valid_q;

endmodule

/* design/serial_link.sv */
module serial_link (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  serial_link_pkg::wb_adr_t  wb_adr_i,
  input  serial_link_pkg::wb_data_t wb_dat_i,
  output serial_link_pkg::wb_data_t wb_dat_o,
  output logic                      wb_ack_o,
  output serial_link_pkg::lane_t    lane_o,
  output logic                      rcv_clk_o,
  input  serial_link_pkg::lane_t    lane_i,
  input  logic                      rcv_clk_i
);

  import serial_link_pkg::*;

  // Control signals from the register file
  logic     tx_en;
  clk_div_t clk_div;
  logic     tx_push, tx_clear, rx_pop, rx_clear;

  // Transmit side
  raw_word_t tx_word, tx_head;
  logic      tx_empty, tx_full, tx_pop;
  fill_t     tx_fill;

  // Receive side
  raw_word_t rx_word, rx_head;
  logic      rx_word_valid, rx_empty, rx_full;
  fill_t     rx_fill;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  serial_link_regs u_regs (
    .clk_i, .rst_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .tx_fill_i       (tx_fill),
    .tx_full_i       (tx_full),
    .rx_word_i       (rx_head),
    .rx_fill_i       (rx_fill),
    .rx_empty_i      (rx_empty),
    .rx_full_i       (rx_full),
    .rx_word_valid_i (rx_word_valid),
    .tx_en_o         (tx_en),
    .clk_div_o       (clk_div),
    .tx_push_o       (tx_push),
    .tx_word_o       (tx_word),
    .tx_clear_o      (tx_clear),
    .rx_pop_o        (rx_pop),
    .rx_clear_o      (rx_clear)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  serial_link_fifo #(.data_t(raw_word_t)) u_tx_fifo (
    .clk_i, .rst_i,
    .clear_i (tx_clear), .push_i (tx_push), .data_i (tx_word), .pop_i (tx_pop),
    .data_o  (tx_head),  .empty_o (tx_empty), .full_o (tx_full), .fill_o (tx_fill)
  );

  serial_link_phy_tx u_phy_tx (
    .clk_i, .rst_i,
    .tx_en_i (tx_en), .clk_div_i (clk_div), .word_i (tx_head), .word_valid_i (~tx_empty),
    .word_pop_o (tx_pop), .lane_o, .rcv_clk_o
  );

  serial_link_phy_rx u_phy_rx (
    .clk_i, .rst_i, .lane_i, .rcv_clk_i,
    .word_o (rx_word), .word_valid_o (rx_word_valid)
  );

  // Words arriving while full are dropped here and flagged by the registers
  serial_link_fifo #(.data_t(raw_word_t)) u_rx_fifo (
    .clk_i, .rst_i,
    .clear_i (rx_clear), .push_i (rx_word_valid), .data_i (rx_word), .pop_i (rx_pop),
    .data_o  (rx_head),  .empty_o (rx_empty), .full_o (rx_full), .fill_o (rx_fill)
  );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  localparam int HalfPeriodNs = 4;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriodNs) clk_o = ~clk_o;
  end

endmodule

/* dv/serial_link_chk.sv */
module serial_link_chk (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic                           cyc_i,
  input logic                           stb_i,
  input logic                           ack_i,
  input logic                           fwd_clk_i,
  input logic                           tx_empty_i,
  input serial_link_pkg::fill_t         tx_fill_i,
  input serial_link_pkg::phy_tx_state_e tx_state_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import serial_link_pkg::*;

  // Ack answers a request seen in the cycle before
  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> $past(cyc_i && stb_i))
    else $error("wb_ack_o high without cyc and stb in the previous cycle");

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |=> !ack_i)
    else $error("wb_ack_o high for two cycles");

  // No forwarded clock without anything to send
  clk_quiet_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (tx_empty_i && (tx_state_i == IDLE)) |-> !fwd_clk_i)
    else $error("rcv_clk_o high while idle with an empty transmit FIFO");

  tx_fill_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_fill_i <= fill_t'(FifoDepth))
    else $error("transmit FIFO fill above its depth");

endmodule

bind serial_link serial_link_chk u_chk (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .cyc_i      (wb_cyc_i),
  .stb_i      (wb_stb_i),
  .ack_i      (wb_ack_o),
  .fwd_clk_i  (rcv_clk_o),
  .tx_empty_i (tx_empty),
  .tx_fill_i  (tx_fill),
  .tx_state_i (u_phy_tx.state_q)
);

/* dv/tb_serial_link.sv */
module tb_serial_link;

  timeunit 1ns;
  timeprecision 100ps;

  import serial_link_pkg::*;

  // About 30 words of 256 cycles at the largest divider, with margin
  localparam int MaxCycles   = 20000;
  localparam int ResetCycles = 16;

  logic     clk, rst;
  logic     wb_cyc, wb_stb, wb_we;
  wb_adr_t  wb_adr;
  wb_data_t wb_wdat, wb_rdat;
  logic     wb_ack;
  lane_t    loop_lane;
  logic     loop_clk;
  logic     loop_clk_prev = 1'b0;

  int errors     = 0;
  int cycles     = 0;
  int beats_seen = 0;
  int seed       = 96;

  tb_clk_gen u_clk_gen (.clk_o(clk));

  // Loopback, transmitter pins straight into the receiver pins
  serial_link DUT (
    .clk_i     (clk),
    .rst_i     (rst),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdat),
    .wb_dat_o  (wb_rdat),
    .wb_ack_o  (wb_ack),
    .lane_o    (loop_lane),
    .rcv_clk_o (loop_clk),
    .lane_i    (loop_lane),
    .rcv_clk_i (loop_clk)
  );

  // Run limit and count of forwarded clock beats on the wire
  always @(posedge clk) begin
    cycles        <= cycles + 1;
    loop_clk_prev <= loop_clk;
    if (loop_clk && !loop_clk_prev) begin
      beats_seen <= beats_seen + 1;
    end
    if (cycles >= MaxCycles) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Bus access
  //////////////////////////////////////////////////////////////////////////

  task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= 1'b1;
    wb_adr  <= adr;
    wb_wdat <= dat;
    do begin
      @(posedge clk);
    end while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do begin
      @(posedge clk);
    end while (!wb_ack);
    dat = wb_rdat;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic check_eq(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_rx_fill(input int n);
    wb_data_t st;
    do begin
      wb_read(RegRxStatus, st);
    end while (st[3:0] != fill_t'(n));
  endtask

  // Waits for room in the transmit FIFO before the write
  task automatic push_tx_word(input raw_word_t w);
    wb_data_t st;
    do begin
      wb_read(RegTxStatus, st);
    end while (st[4]);
    wb_write(RegTxData, wb_data_t'(w));
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    wb_data_t rd;
    wb_read(RegClkDiv, rd);
    check_eq("clk_div", rd, 32'd8);
    wb_read(RegCtrl, rd);
    check_eq("ctrl", rd, 32'd0);
    wb_read(RegTxStatus, rd);
    check_eq("tx_status", rd, 32'd0);
    wb_read(RegRxStatus, rd);
    check_eq("rx_status", rd, 32'd0);
    wb_write(RegClkDiv, 32'd2);
    wb_read(RegClkDiv, rd);
    check_eq("clk_div", rd, 32'd4);
    wb_write(RegClkDiv, 32'd100);
    wb_read(RegClkDiv, rd);
    check_eq("clk_div", rd, 32'd64);
    wb_read(8'h20, rd);
    check_eq("unmapped", rd, 32'd0);
  endtask

  task automatic test_single_word();
    raw_word_t w;
    wb_data_t  rd;
    w = 16'hA5C3;
    wb_write(RegClkDiv, 32'd8);
    wb_write(RegCtrl, 32'd1);
    wb_write(RegTxData, wb_data_t'(w));
    wait_rx_fill(1);
    wb_read(RegRxData, rd);
    check_eq("rx_data", rd, {15'd0, 1'b1, w});
    wb_read(RegRxData, rd);
    check_eq("rx_valid", wb_data_t'(rd[16]), 32'd0);
  endtask

  task automatic test_random_burst();
    raw_word_t words[$];
    raw_word_t w;
    wb_data_t  rd;
    wb_write(RegCtrl, 32'd0);
    wb_write(RegClkDiv, 32'd4);
    for (int i = 0; i < 8; i++) begin
      w = raw_word_t'($random(seed));
      words.push_back(w);
      wb_write(RegTxData, wb_data_t'(w));
    end
    wb_write(RegCtrl, 32'd1);
    wait_rx_fill(8);
    foreach (words[i]) begin
      wb_read(RegRxData, rd);
      check_eq("rx_data", rd, {15'd0, 1'b1, words[i]});
    end
    wb_read(RegTxStatus, rd);
    check_eq("tx_status", rd, 32'd0);
  endtask

  task automatic test_tx_hold();
    wb_data_t rd;
    wb_write(RegCtrl, 32'd0);
    for (int i = 0; i < 3; i++) begin
      wb_write(RegTxData, wb_data_t'(raw_word_t'($random(seed))));
    end
    wb_read(RegTxStatus, rd);
    check_eq("tx_status", rd, 32'h03);
    repeat (200) @(posedge clk);
    wb_read(RegRxStatus, rd);
    check_eq("rx_status", rd, 32'h00);
    // Ninth word finds the FIFO full and is dropped
    for (int i = 0; i < 6; i++) begin
      wb_write(RegTxData, wb_data_t'(raw_word_t'($random(seed))));
    end
    wb_read(RegTxStatus, rd);
    check_eq("tx_status", rd, 32'h18);
    wb_write(RegFifoClear, 32'd1);
    wb_read(RegTxStatus, rd);
    check_eq("tx_status", rd, 32'h00);
  endtask

  task automatic test_rx_overflow();
    raw_word_t words[$];
    raw_word_t w;
    wb_data_t  rd;
    int        beat_target;
    wb_write(RegClkDiv, 32'd4);
    wb_write(RegCtrl, 32'd1);
    beat_target = beats_seen + 10 * BeatsPerWord;
    for (int i = 0; i < 10; i++) begin
      w = raw_word_t'($random(seed));
      words.push_back(w);
      push_tx_word(w);
    end
    while (beats_seen < beat_target) begin
      @(posedge clk);
    end
    // Last beat still crosses the synchronizer before the drop
    repeat (8) @(posedge clk);
    wb_read(RegRxStatus, rd);
    check_eq("rx_status", rd, 32'h18);
    wb_read(RegRxStatus, rd);
    check_eq("rx_status", rd, 32'h08);
    for (int i = 0; i < 8; i++) begin
      wb_read(RegRxData, rd);
      check_eq("rx_data", rd, {15'd0, 1'b1, words[i]});
    end
  endtask

  task automatic test_rx_clear();
    raw_word_t w;
    wb_data_t  rd;
    for (int i = 0; i < 3; i++) begin
      push_tx_word(raw_word_t'($random(seed)));
    end
    wait_rx_fill(3);
    wb_write(RegFifoClear, 32'd2);
    wb_read(RegRxStatus, rd);
    check_eq("rx_status", rd, 32'h00);
    w = raw_word_t'($random(seed));
    push_tx_word(w);
    wait_rx_fill(1);
    wb_read(RegRxData, rd);
    check_eq("rx_data", rd, {15'd0, 1'b1, w});
  endtask

  initial begin
    rst     <= 1'b1;
    wb_cyc  <= 1'b0;
    wb_stb  <= 1'b0;
    wb_we   <= 1'b0;
    wb_adr  <= '0;
    wb_wdat <= '0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    test_reset_values();
    test_single_word();
    test_random_burst();
    test_tx_hold();
    test_rx_overflow();
    test_rx_clear();
    $display("Tests done after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* sources.f */
common/serial_link_pkg.sv
design/serial_link_fifo.sv
design/serial_link_regs.sv
phy/serial_link_phy_tx.sv
phy/serial_link_phy_rx.sv
design/serial_link.sv
dv/tb_clk_gen.sv
dv/serial_link_chk.sv
dv/tb_serial_link.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_serial_link
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
